/* design/mbist_pkg.sv */
/*
  Shared widths, reset window, register map and March C- element codes.
  The SRAM is fixed at 9 address bits by 32 data bits.
  Register offsets are byte addresses on a 5-bit AXI4-Lite address.
  The element order follows March C-; the sequencer steps through it by increment.
*/
package mbist_pkg;

  localparam int addr_wd   = 9;             // SRAM address bits
  localparam int data_wd   = 32;            // SRAM data bits
  localparam int chain_len = 2 * addr_wd;   // End then start register

  // Window after reset
  localparam logic [addr_wd-1:0] addr_start_def = 9'h000;
  localparam logic [addr_wd-1:0] addr_end_def   = 9'h1F8;

  // AXI4-Lite register map
  localparam logic [4:0] reg_ctrl      = 5'h00;  // W: bit 0 start
  localparam logic [4:0] reg_range     = 5'h04;  // Start 8:0, end 24:16
  localparam logic [4:0] reg_pattern   = 5'h08;  // Background word
  localparam logic [4:0] reg_status    = 5'h0C;  // Busy, done, fail
  localparam logic [4:0] reg_fail_addr = 5'h10;
  localparam logic [4:0] reg_fail_data = 5'h14;

  // March C- elements in test order
  typedef enum logic [2:0] {
    e_w0      = 3'd0,  // Up, write 0
    e_r0w1_up = 3'd1,
    e_r1w0_up = 3'd2,
    e_r0w1_dn = 3'd3,
    e_r1w0_dn = 3'd4,
    e_r0      = 3'd5   // Final read, run upward
  } march_elem_e;

endpackage

/* design/mbist_addr_gen.sv */
/*
  Window address counter for the March sequencer.
  Start and end registers load only through the serial chain; one chain
  of 18 bits, sdi into start MSB, start LSB into end MSB.
  The window is assumed ordered, start not above end.
  scan_load has priority over run.
*/
module mbist_addr_gen (
  output logic                          last_addr,   // On final address of this pass
  output logic [mbist_pkg::addr_wd-1:0] bist_addr,   // Current test address
  output logic                          sdo,         // Chain tail
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          run,         // Advance one address
  input  logic                          updown,      // 1 up, 0 down
  input  logic                          scan_shift,
  input  logic                          scan_load,   // Counter to window start
  input  logic                          sdi
);

  import mbist_pkg::*;

  logic [addr_wd-1:0] start_addr;
  logic [addr_wd-1:0] end_addr;
  logic [addr_wd-1:0] next_addr;

  // Final address depends on direction
  assign last_addr = updown ? (bist_addr == end_addr) : (bist_addr == start_addr);

  assign sdo = end_addr[0];

  //////////////////////////////////////////////////////////////////////
  // Counter
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    next_addr = bist_addr;                   // Hold without run
    if (run) begin
      if (last_addr) begin
        next_addr = updown ? start_addr : end_addr;  // Wrap at window edge
      end else begin
        next_addr = updown ? bist_addr + 1'b1 : bist_addr - 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bist_addr <= addr_start_def;
    end else if (scan_load) begin
      bist_addr <= start_addr;
    end else begin
      bist_addr <= next_addr;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Scan chain, start feeds end
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_addr <= addr_start_def;
      end_addr   <= addr_end_def;
    end else if (scan_shift) begin
      start_addr <= {sdi, start_addr[addr_wd-1:1]};
      end_addr   <= {start_addr[0], end_addr[addr_wd-1:1]};
    end
  end

endmodule

/* design/mbist_pat_gen.sv */
/*
  Expected and write data for the current March element.
  Polarity 0 is the background, polarity 1 its inverse.
  Data is captured only on an element change, so a new background
  takes effect at the next run. Outputs lag elem by one clock; the
  sequencer's gap cycle covers that.
*/
module mbist_pat_gen (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [mbist_pkg::data_wd-1:0] pattern,   // Background from host
  input  mbist_pkg::march_elem_e        elem,
  output logic [mbist_pkg::data_wd-1:0] exp_data,  // Compare value
  output logic [mbist_pkg::data_wd-1:0] wr_data
);

  import mbist_pkg::*;

  march_elem_e elem_q;   // Element seen last clock
  logic        exp_inv;
  logic        wr_inv;

  // Polarity per element
  always_comb begin
    case (elem)
      e_r0w1_up, e_r0w1_dn: begin
        exp_inv = 1'b0;
        wr_inv  = 1'b1;
      end
      e_r1w0_up, e_r1w0_dn: begin
        exp_inv = 1'b1;
        wr_inv  = 1'b0;
      end
      default: begin        // w0 and final r0
        exp_inv = 1'b0;
        wr_inv  = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      elem_q <= e_r0;       // Matches sequencer idle element
    end else begin
      elem_q <= elem;
    end
  end

  always_ff @(posedge clk) begin
    if (elem != elem_q) begin
      exp_data <= exp_inv ? ~pattern : pattern;
      wr_data  <= wr_inv ? ~pattern : pattern;
    end
  end

endmodule

/* design/mbist_march_fsm.sv */
/*
  March C- sequencer. Writes take one cycle, read-write pairs two,
  r-only one plus a final compare cycle, with one gap cycle per element.
  Read data is compared a clock after the read against the registered
  address. The first mismatch stops the test; the SRAM access in that
  cycle is dropped.
*/
module mbist_march_fsm (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start,       // One-cycle request
  input  logic                          last_addr,
  input  logic [mbist_pkg::addr_wd-1:0] bist_addr,
  input  logic [mbist_pkg::data_wd-1:0] exp_data,
  input  logic [mbist_pkg::data_wd-1:0] wr_data,
  input  logic [mbist_pkg::data_wd-1:0] mem_rdata,
  output logic                          run,
  output logic                          updown,
  output mbist_pkg::march_elem_e        elem,
  output logic                          rewind,      // Counter back to start
  output logic                          busy,
  output logic                          done_pulse,
  output logic                          fail_pulse,
  output logic [mbist_pkg::addr_wd-1:0] fail_addr,
  output logic [mbist_pkg::data_wd-1:0] fail_data,
  output logic                          mem_cs,
  output logic                          mem_we,
  output logic [mbist_pkg::addr_wd-1:0] mem_addr,
  output logic [mbist_pkg::data_wd-1:0] mem_wdata
);

  import mbist_pkg::*;

  typedef enum logic [2:0] {s_idle, s_gap, s_rd, s_wr, s_tail} state_e;

  state_e             state;
  state_e             state_nx;
  march_elem_e        elem_nx;
  logic               rd_pend;     // Read data due this cycle
  logic [addr_wd-1:0] rd_addr_q;   // Address of that read
  logic               mismatch;
  logic               wr_only;
  logic               rd_only;
  logic               dn_elem;

  assign wr_only  = (elem == e_w0);
  assign rd_only  = (elem == e_r0);
  assign dn_elem  = (elem == e_r0w1_dn) || (elem == e_r1w0_dn);
  assign updown   = ~dn_elem;
  assign busy     = (state != s_idle);
  assign mismatch = rd_pend && (mem_rdata != exp_data);

  assign mem_addr  = bist_addr;
  assign mem_wdata = wr_data;

  //////////////////////////////////////////////////////////////////////
  // Next state and SRAM strobes
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nx   = state;
    elem_nx    = elem;
    run        = 1'b0;
    rewind     = 1'b0;
    mem_cs     = 1'b0;
    mem_we     = 1'b0;
    done_pulse = 1'b0;
    fail_pulse = 1'b0;
    case (state)
      s_idle: begin
        if (start) begin
          state_nx = s_gap;
          elem_nx  = e_w0;
        end
      end
      s_gap: begin
        // Up elements restart at window start; down ones wrap to end
        rewind   = ~dn_elem;
        run      = dn_elem & last_addr;
        state_nx = wr_only ? s_wr : s_rd;
      end
      s_rd: begin
        mem_cs = 1'b1;
        if (rd_only) begin
          run = 1'b1;
          if (last_addr) state_nx = s_tail;
        end else begin
          state_nx = s_wr;     // Write while compare completes
        end
      end
      s_wr: begin
        mem_cs = 1'b1;
        mem_we = 1'b1;
        run    = 1'b1;
        if (last_addr) begin
          state_nx = s_gap;
          elem_nx  = march_elem_e'(elem + 3'd1);
        end else if (!wr_only) begin
          state_nx = s_rd;
        end
      end
      s_tail: begin          // Last r0 compare
        done_pulse = 1'b1;
        state_nx   = s_idle;
      end
      default: state_nx = s_idle;
    endcase

    if (mismatch) begin      // First failure ends the test
      mem_cs     = 1'b0;
      mem_we     = 1'b0;
      run        = 1'b0;
      rewind     = 1'b0;
      done_pulse = 1'b1;
      fail_pulse = 1'b1;
      state_nx   = s_idle;
      elem_nx    = e_r0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= s_idle;
      elem    <= e_r0;       // Idle element, start always changes it
      rd_pend <= 1'b0;
    end else begin
      state   <= state_nx;
      elem    <= elem_nx;
      rd_pend <= mem_cs & ~mem_we;
    end
  end

  // Compare address and failure capture
  always_ff @(posedge clk) begin
    if (mem_cs && !mem_we) rd_addr_q <= bist_addr;
    if (mismatch) begin
      fail_addr <= rd_addr_q;
      fail_data <= mem_rdata;
    end
  end

endmodule

/* design/mbist_axil_regs.sv */
/*
  AXI4-Lite slave with the MBIST register file and window loader.
  One write or read outstanding; responses always OKAY, wstrb not
  supported, so every write is a full word.
  A RANGE write is refused while busy or while a load is running.
  A start is refused while busy or loading.
*/
module mbist_axil_regs (
  input  logic                          clk,
  input  logic                          rst_n,
  // Write channels
  input  logic [4:0]                    awaddr,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [31:0]                   wdata,
  input  logic [3:0]                    wstrb,      // Unsupported
  input  logic                          wvalid,
  output logic                          wready,
  output logic [1:0]                    bresp,
  output logic                          bvalid,
  input  logic                          bready,
  // Read channels
  input  logic [4:0]                    araddr,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [31:0]                   rdata,
  output logic [1:0]                    rresp,
  output logic                          rvalid,
  input  logic                          rready,
  // Sequencer side
  input  logic                          busy,
  input  logic                          done_pulse,
  input  logic                          fail_pulse,
  input  logic [mbist_pkg::addr_wd-1:0] fail_addr,
  input  logic [mbist_pkg::data_wd-1:0] fail_data,
  output logic                          start,
  output logic [mbist_pkg::data_wd-1:0] pattern,
  output logic                          scan_shift,
  output logic                          scan_load_req,
  output logic                          sdi
);

  import mbist_pkg::*;

  logic                 wr_acc;
  logic                 rd_acc;
  logic                 loading;
  logic                 range_wr;
  logic                 done_q;
  logic                 fail_q;
  logic [addr_wd-1:0]   range_start;
  logic [addr_wd-1:0]   range_end;
  logic [chain_len-1:0] shift_q;     // LSB goes out first
  logic [4:0]           ld_cnt;      // Shift plus load cycles left
  logic [31:0]          rd_mux;

  //////////////////////////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////////////////////////

  assign wr_acc  = awvalid & wvalid & ~bvalid;
  assign rd_acc  = arvalid & ~rvalid;
  assign awready = wr_acc;
  assign wready  = wr_acc;
  assign arready = rd_acc;
  assign bresp   = 2'b00;
  assign rresp   = 2'b00;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (wr_acc)      bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
      if (rd_acc)      rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  assign loading  = (ld_cnt != '0);
  assign range_wr = wr_acc && (awaddr == reg_range) && !busy && !loading;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start       <= 1'b0;
      pattern     <= '0;
      range_start <= addr_start_def;
      range_end   <= addr_end_def;
      done_q      <= 1'b0;
      fail_q      <= 1'b0;
    end else begin
      start <= wr_acc && (awaddr == reg_ctrl) && wdata[0] && !busy && !loading;
      if (wr_acc && (awaddr == reg_pattern)) pattern <= wdata;
      if (range_wr) begin
        range_start <= wdata[addr_wd-1:0];
        range_end   <= wdata[16+addr_wd-1:16];
      end
      if (start) begin         // New run clears sticky result
        done_q <= 1'b0;
        fail_q <= 1'b0;
      end else begin
        if (done_pulse) done_q <= 1'b1;
        if (fail_pulse) fail_q <= 1'b1;
      end
    end
  end

  always_comb begin
    case (araddr)
      reg_range:     rd_mux = {{(16-addr_wd){1'b0}}, range_end,
                               {(16-addr_wd){1'b0}}, range_start};
      reg_pattern:   rd_mux = pattern;
      reg_status:    rd_mux = {29'd0, fail_q, done_q, busy};
      reg_fail_addr: rd_mux = {{(32-addr_wd){1'b0}}, fail_addr};
      reg_fail_data: rd_mux = fail_data;
      default:       rd_mux = '0;  // CTRL is write only
    endcase
  end

  always_ff @(posedge clk) begin
    if (rd_acc) rdata <= rd_mux;
  end

  //////////////////////////////////////////////////////////////////////
  // Window loader, 18 shifts then one load
  //////////////////////////////////////////////////////////////////////

  assign scan_shift    = (ld_cnt > 5'd1);
  assign scan_load_req = (ld_cnt == 5'd1);
  assign sdi           = shift_q[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ld_cnt <= '0;
    end else if (range_wr) begin
      ld_cnt <= 5'(chain_len + 1);
    end else if (loading) begin
      ld_cnt <= ld_cnt - 5'd1;
    end
  end

  // End address leaves first so it lands in the tail register
  always_ff @(posedge clk) begin
    if (range_wr) begin
      shift_q <= {wdata[addr_wd-1:0], wdata[16+addr_wd-1:16]};
    end else if (scan_shift) begin
      shift_q <= {1'b0, shift_q[chain_len-1:1]};
    end
  end

endmodule

/* design/mbist_top.sv */
/*
  MBIST controller top. One external single-port SRAM, 512 x 32,
  with one-cycle read latency.
  sdo is the address chain tail, brought out as status only.
*/
module mbist_top (
  input  logic                          clk,
  input  logic                          rst_n,
  // AXI4-Lite slave
  input  logic [4:0]                    awaddr,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [31:0]                   wdata,
  input  logic [3:0]                    wstrb,
  input  logic                          wvalid,
  output logic                          wready,
  output logic [1:0]                    bresp,
  output logic                          bvalid,
  input  logic                          bready,
  input  logic [4:0]                    araddr,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [31:0]                   rdata,
  output logic [1:0]                    rresp,
  output logic                          rvalid,
  input  logic                          rready,
  // SRAM port
  output logic                          mem_cs,
  output logic                          mem_we,
  output logic [mbist_pkg::addr_wd-1:0] mem_addr,
  output logic [mbist_pkg::data_wd-1:0] mem_wdata,
  input  logic [mbist_pkg::data_wd-1:0] mem_rdata,
  output logic                          sdo
);

  import mbist_pkg::*;

  logic               start, busy, done_pulse, fail_pulse;
  logic               scan_shift, scan_load_req, sdi, rewind, scan_load;
  logic               run, updown, last_addr;
  logic [addr_wd-1:0] bist_addr, fail_addr;
  logic [data_wd-1:0] pattern, fail_data, exp_data, wr_data;
  march_elem_e        elem;

  assign scan_load = scan_load_req | rewind;  // Host load or element restart

  mbist_axil_regs i_regs (
    .clk, .rst_n,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .busy, .done_pulse, .fail_pulse, .fail_addr, .fail_data,
    .start, .pattern, .scan_shift, .scan_load_req, .sdi
  );

  mbist_addr_gen i_addr_gen (
    .last_addr, .bist_addr, .sdo,
    .clk, .rst_n, .run, .updown, .scan_shift, .scan_load, .sdi
  );

  mbist_pat_gen i_pat_gen (
    .clk, .rst_n, .pattern, .elem, .exp_data, .wr_data
  );

  mbist_march_fsm i_march_fsm (
    .clk, .rst_n, .start, .last_addr, .bist_addr, .exp_data, .wr_data,
    .mem_rdata, .run, .updown, .elem, .rewind, .busy, .done_pulse,
    .fail_pulse, .fail_addr, .fail_data,
    .mem_cs, .mem_we, .mem_addr, .mem_wdata
  );

endmodule

/* bench/tb_sram_model.sv */
/*
  Behavioral 512 x 32 single-port SRAM, one-cycle read latency.
  Contents are not reset; the bench presets them directly.
  One optional stuck-at bit, applied on the read path only.
*/
module tb_sram_model (
  input  logic                          clk,
  input  logic                          cs,
  input  logic                          we,
  input  logic [mbist_pkg::addr_wd-1:0] addr,
  input  logic [mbist_pkg::data_wd-1:0] wdata,
  output logic [mbist_pkg::data_wd-1:0] rdata
);

  import mbist_pkg::*;

  logic [data_wd-1:0] mem [0:(1<<addr_wd)-1];
  logic               fault_en;     // Set by the bench
  logic [addr_wd-1:0] fault_addr;
  logic [4:0]         fault_bit;
  logic               fault_val;    // Stuck value

  // Stored word with the stuck bit forced
  function automatic logic [data_wd-1:0] read_word(input logic [addr_wd-1:0] a);
    logic [data_wd-1:0] w;
    w = mem[a];
    if (fault_en && (a == fault_addr)) w[fault_bit] = fault_val;
    return w;
  endfunction

  always @(posedge clk) begin
    if (cs && we) mem[addr] <= wdata;
    if (cs && !we) rdata <= read_word(addr);   // Valid next cycle
  end

endmodule

/* bench/mbist_sva.sv */
/*
  Protocol checks bound into mbist_top.
  Watches the AXI response handshakes, the SRAM select and the
  sequencer's busy and start. All checks are off during reset.
*/
module mbist_sva (
  input logic clk,
  input logic rst_n,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready,
  input logic mem_cs,
  input logic busy,
  input logic start
);

  int fail_cnt = 0;   // Failed assertions so far

  // Responses hold until taken
  bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
    else begin
      $error("bvalid dropped before bready");
      fail_cnt++;
    end

  rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid)
    else begin
      $error("rvalid dropped before rready");
      fail_cnt++;
    end

  // SRAM quiet outside a run
  cs_only_busy: assert property (@(posedge clk) disable iff (!rst_n)
    !busy |-> !mem_cs)
    else begin
      $error("mem_cs high while not busy");
      fail_cnt++;
    end

  // A run begins only from a start pulse
  busy_after_start: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(busy) |-> $past(start))
    else begin
      $error("busy rose without start");
      fail_cnt++;
    end

endmodule

/* bench/tb_mbist.sv */
/*
  Directed testbench for mbist_top with a behavioral SRAM.
  AXI inputs change on rising edges, outputs are sampled on falling edges.
  The RANGE loader takes a fixed 19 cycles, so the bench waits that long
  after each accepted RANGE write before it starts a run.
*/
module tb_mbist;

  import mbist_pkg::*;

  localparam int              hs_limit   = 50;      // Cycles per AXI handshake
  localparam int              poll_limit = 8000;    // STATUS polls per run
  localparam logic [addr_wd-1:0] win_lo  = 9'h040;  // Reduced window
  localparam logic [addr_wd-1:0] win_hi  = 9'h07F;

  logic               clk;
  logic               rst_n;
  logic [4:0]         awaddr;
  logic               awvalid;
  logic               awready;
  logic [31:0]        wdata;
  logic [3:0]         wstrb;
  logic               wvalid;
  logic               wready;
  logic [1:0]         bresp;
  logic               bvalid;
  logic               bready;
  logic [4:0]         araddr;
  logic               arvalid;
  logic               arready;
  logic [31:0]        rdata;
  logic [1:0]         rresp;
  logic               rvalid;
  logic               rready;
  logic               mem_cs;
  logic               mem_we;
  logic [addr_wd-1:0] mem_addr;
  logic [data_wd-1:0] mem_wdata;
  logic [data_wd-1:0] mem_rdata;
  logic               sdo;          // Chain tail

  int                 seed      = 89097;
  int                 err_cnt   = 0;
  int                 test_cnt  = 0;
  int                 test_fail = 0;
  int                 done_cnt  = 0;  // Done pulses seen
  logic [data_wd-1:0] bg_clean;       // Background of the clean run

  mbist_top i_mbist_top (
    .clk, .rst_n,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .mem_cs, .mem_we, .mem_addr, .mem_wdata, .mem_rdata, .sdo
  );

  tb_sram_model i_sram (
    .clk, .cs(mem_cs), .we(mem_we), .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
  );

  bind mbist_top mbist_sva i_sva (
    .clk(clk), .rst_n(rst_n), .bvalid(bvalid), .bready(bready), .rvalid(rvalid),
    .rready(rready), .mem_cs(mem_cs), .busy(busy), .start(start)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(negedge clk) begin
    if (rst_n && i_mbist_top.done_pulse) done_cnt++;   // One per finished run
  end

  //////////////////////////////////////////////////////////////////////
  // Check and report helpers
  //////////////////////////////////////////////////////////////////////

  task automatic compare_word(input string test, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("error %s: %s expected %h actual %h", test, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic require_true(input string test, input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("%s: %s", test, what);
      err_cnt++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout waiting for %s", what);
    err_cnt++;
  endtask

  task automatic close_test(input string test, input int err_start);
    test_cnt++;
    if (err_cnt == err_start) begin
      $display("test %s: ok", test);
    end else begin
      test_fail++;
      $display("test %s: failed with %0d errors", test, err_cnt - err_start);
    end
  endtask

  // Marker word, unique per address
  function automatic logic [31:0] marker_word(input logic [addr_wd-1:0] a);
    return {7'h2D, a, 7'h52, ~a};
  endfunction

  // First failing read under March C-: read polarities r0 r1 r0 r1 r0
  function automatic logic [31:0] expected_fail_word(input logic [31:0] bg,
                                                     input int fbit, input logic stuck);
    logic [4:0]  rd_pol;
    logic [31:0] word;
    rd_pol = 5'b01010;   // Bit i is read element i
    word   = bg;
    for (int i = 0; i < 5; i++) begin
      word = rd_pol[i] ? ~bg : bg;
      if (word[fbit] != stuck) break;
    end
    word[fbit] = stuck;
    return word;
  endfunction

  task automatic preset_memory();
    for (int a = 0; a < (1 << addr_wd); a++) begin
      i_sram.mem[a] = marker_word(a[addr_wd-1:0]);
    end
  endtask

  // Background inside the window, markers elsewhere
  task automatic verify_window(input string test, input logic [addr_wd-1:0] lo,
                               input logic [addr_wd-1:0] hi, input logic [31:0] bg);
    logic [31:0] exp;
    for (int a = 0; a < (1 << addr_wd); a++) begin
      exp = (a >= lo && a <= hi) ? bg : marker_word(a[addr_wd-1:0]);
      compare_word(test, $sformatf("word %h", a), exp, i_sram.mem[a]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // AXI4-Lite driver
  //////////////////////////////////////////////////////////////////////

  task automatic axi_write(input logic [4:0] addr, input logic [31:0] data);
    int   n;
    logic ok;
    @(posedge clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hF;
    wvalid  <= 1'b1;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < hs_limit) begin
      @(negedge clk);
      ok = awready & wready;   // Taken at the next edge
      n++;
    end
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    if (!ok) begin
      report_timeout("write address and data acceptance");
    end else begin
      bready <= 1'b1;
      n  = 0;
      ok = 1'b0;
      while (!ok && n < hs_limit) begin
        @(negedge clk);
        ok = bvalid;
        n++;
      end
      if (ok) require_true("axi_write", bresp == 2'b00, "write response not OKAY");
      @(posedge clk);
      bready <= 1'b0;
      if (!ok) report_timeout("write response");
    end
  endtask

  task automatic axi_read(input logic [4:0] addr, output logic [31:0] data);
    int   n;
    logic ok;
    data = '0;
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < hs_limit) begin
      @(negedge clk);
      ok = arready;
      n++;
    end
    @(posedge clk);
    arvalid <= 1'b0;
    if (!ok) begin
      report_timeout("read address acceptance");
    end else begin
      rready <= 1'b1;
      n  = 0;
      ok = 1'b0;
      while (!ok && n < hs_limit) begin
        @(negedge clk);
        ok = rvalid;
        n++;
      end
      if (ok) begin
        data = rdata;
        require_true("axi_read", rresp == 2'b00, "read response not OKAY");
      end
      @(posedge clk);
      rready <= 1'b0;
      if (!ok) report_timeout("read data");
    end
  endtask

  // RANGE write, then the loader's fixed 18 shifts and one load
  task automatic load_range(input logic [addr_wd-1:0] lo, input logic [addr_wd-1:0] hi);
    axi_write(reg_range, {7'd0, hi, 7'd0, lo});
    repeat (chain_len + 1) @(posedge clk);
  endtask

  task automatic request_start();
    axi_write(reg_ctrl, 32'h1);
  endtask

  task automatic wait_done(output logic [31:0] status);
    int n;
    n      = 0;
    status = '0;
    while (!status[1] && n < poll_limit) begin
      axi_read(reg_status, status);
      n++;
    end
    if (!status[1]) report_timeout("done bit in STATUS");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    string       t  = "reset_state";
    int          e0 = err_cnt;
    logic [31:0] d;
    axi_read(reg_range, d);
    compare_word(t, "RANGE", 32'h01F8_0000, d);
    axi_read(reg_status, d);
    compare_word(t, "STATUS", 32'h0, d);
    axi_read(reg_pattern, d);
    compare_word(t, "PATTERN", 32'h0, d);
    require_true(t, !mem_cs && !mem_we, "SRAM strobes active after reset");
    close_test(t, e0);
  endtask

  task automatic test_register_access();
    string              t  = "register_access";
    int                 e0 = err_cnt;
    logic [31:0]        pat;
    logic [31:0]        rng;
    logic [31:0]        d;
    logic [addr_wd-1:0] lo;
    logic [addr_wd-1:0] hi;
    pat = $random(seed);
    axi_write(reg_pattern, pat);
    axi_read(reg_pattern, d);
    compare_word(t, "PATTERN", pat, d);
    d  = $random(seed);
    lo = {1'b0, d[7:0]};
    hi = lo + 9'd16 + {4'd0, d[12:8]};   // Ordered, inside 512
    rng = {7'd0, hi, 7'd0, lo};
    load_range(lo, hi);
    compare_word(t, "sdo", {31'd0, hi[0]}, {31'd0, sdo});  // Tail holds end LSB
    axi_read(reg_range, d);
    compare_word(t, "RANGE", rng, d);
    request_start();
    axi_read(reg_status, d);
    require_true(t, d[0], "run did not go busy");
    axi_write(reg_range, {7'd0, 9'h1F0, 7'd0, 9'h010});  // Refused while busy
    axi_read(reg_range, d);
    compare_word(t, "RANGE while busy", rng, d);
    wait_done(d);
    compare_word(t, "STATUS", 32'h2, d);
    close_test(t, e0);
  endtask

  task automatic test_clean_run();
    string       t  = "clean_run";
    int          e0 = err_cnt;
    logic [31:0] d;
    bg_clean = $random(seed);
    preset_memory();
    load_range(addr_start_def, addr_end_def);
    axi_write(reg_pattern, bg_clean);
    request_start();
    wait_done(d);
    compare_word(t, "STATUS", 32'h2, d);
    verify_window(t, addr_start_def, addr_end_def, bg_clean);
    close_test(t, e0);
  endtask

  // Stuck value chosen so the first or the second read element fails
  task automatic test_stuck_fault(input logic later);
    string              t;
    int                 e0;
    int                 fbit;
    logic [31:0]        bg;
    logic [31:0]        d;
    logic [31:0]        exp_word;
    logic [addr_wd-1:0] faddr;
    logic               stuck;
    t        = later ? "fault_later_elem" : "fault_first_elem";
    e0       = err_cnt;
    bg       = $random(seed);
    d        = $random(seed);
    faddr    = win_lo + {3'd0, d[5:0]};
    fbit     = d[12:8];
    stuck    = later ? bg[fbit] : ~bg[fbit];
    exp_word = expected_fail_word(bg, fbit, stuck);
    preset_memory();
    i_sram.fault_addr = faddr;
    i_sram.fault_bit  = fbit[4:0];
    i_sram.fault_val  = stuck;
    i_sram.fault_en   = 1'b1;
    load_range(win_lo, win_hi);
    axi_write(reg_pattern, bg);
    request_start();
    wait_done(d);
    compare_word(t, "STATUS", 32'h6, d);
    axi_read(reg_fail_addr, d);
    compare_word(t, "FAIL_ADDR", {23'd0, faddr}, d);
    axi_read(reg_fail_data, d);
    compare_word(t, "FAIL_DATA", exp_word, d);
    i_sram.fault_en = 1'b0;
    close_test(t, e0);
  endtask

  task automatic test_fault_outside();
    string       t  = "fault_outside";
    int          e0 = err_cnt;
    logic [31:0] bg;
    logic [31:0] d;
    bg = $random(seed);
    d  = $random(seed);
    preset_memory();
    i_sram.fault_addr = 9'h100;          // Beyond win_hi
    i_sram.fault_bit  = d[4:0];
    i_sram.fault_val  = ~bg[d[4:0]];
    i_sram.fault_en   = 1'b1;
    load_range(win_lo, win_hi);
    axi_write(reg_pattern, bg);
    request_start();
    wait_done(d);
    compare_word(t, "STATUS", 32'h2, d);
    verify_window(t, win_lo, win_hi, bg);
    i_sram.fault_en = 1'b0;
    close_test(t, e0);
  endtask

  task automatic test_start_while_busy();
    string       t  = "start_while_busy";
    int          e0 = err_cnt;
    logic [31:0] d;
    preset_memory();
    load_range(addr_start_def, addr_end_def);
    axi_write(reg_pattern, bg_clean);
    done_cnt = 0;
    request_start();
    axi_read(reg_status, d);
    require_true(t, d[0], "run did not go busy");
    request_start();                     // Second start mid-run
    wait_done(d);
    compare_word(t, "STATUS", 32'h2, d);
    compare_word(t, "done pulses", 32'd1, done_cnt);
    verify_window(t, addr_start_def, addr_end_def, bg_clean);
    close_test(t, e0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    i_sram.fault_en   = 1'b0;
    i_sram.fault_addr = '0;
    i_sram.fault_bit  = '0;
    i_sram.fault_val  = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    test_reset_state();
    test_register_access();
    test_clean_run();
    test_stuck_fault(1'b0);
    test_stuck_fault(1'b1);
    test_fault_outside();
    test_start_while_busy();

    err_cnt += i_mbist_top.i_sva.fail_cnt;   // Bound protocol checks
    $display("tests %0d, failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* mbist_lite.f */
design/mbist_pkg.sv
design/mbist_addr_gen.sv
design/mbist_pat_gen.sv
design/mbist_march_fsm.sv
design/mbist_axil_regs.sv
design/mbist_top.sv
bench/tb_sram_model.sv
bench/mbist_sva.sv
bench/tb_mbist.sv
